/* src/fp_pkg.sv */
package fp_pkg;

	// ====================================================================
	// binary32 format
	// ====================================================================

	// full operand width in bits
	localparam int fp_wid = 32;

	// top bit of the 8-bit biased exponent field
	localparam int fp_emsb = 7;

	// top bit of the 23-bit fraction field
	localparam int fp_fmsb = 22;

	// sign sits at fp_wid-1
	// exponent occupies fp_wid-2 down to fp_fmsb+1
	// fraction occupies fp_fmsb down to 0

	// ====================================================================
	// compare predicates
	// ====================================================================

	// eq  true when a == b
	// ne  true when a != b or when either operand is nan
	// lt  true when a < b
	// le  true when a <= b
	// gt  true when a > b
	// ge  true when a >= b
	// or  true when both operands are ordered
	// un  true when at least one operand is nan
	//
	// lt/le/gt/ge are the signaling predicates
	// any nan operand on these raises invalid
	// eq/ne/or/un are quiet and only a signaling nan raises invalid
	typedef enum logic [2:0] {
		cmp_eq = 3'd0,
		cmp_ne = 3'd1,
		cmp_lt = 3'd2,
		cmp_le = 3'd3,
		cmp_gt = 3'd4,
		cmp_ge = 3'd5,
		cmp_or = 3'd6,
		cmp_un = 3'd7
	} cmp_op_e;

	// ====================================================================
	// condition vector layout
	// ====================================================================

	// a equals b
	// forced low when unordered
	localparam int cond_eq  = 0;

	// a less than b
	// forced low when unordered
	localparam int cond_lt  = 1;

	// a less than or equal to b
	// forced low when unordered
	localparam int cond_le  = 2;

	// raw magnitude of a below magnitude of b
	// ignores sign and nan
	localparam int cond_mlt = 3;

	// either operand is a nan
	localparam int cond_un  = 4;

	// number of condition bits
	localparam int cond_w   = 5;

endpackage

/* src/fp_parts_if.sv */
// one binary32 operand split into fields and class flags
// plain combinational levels with no handshake
interface fp_parts_if;

	// sign bit
	logic                   sgn;
	// biased exponent
	logic [fp_pkg::fp_emsb:0] exp;
	// stored fraction without the hidden bit
	logic [fp_pkg::fp_fmsb:0] man;

	// class flags
	logic                   zero;
	logic                   nan;
	logic                   qnan;
	logic                   snan;

	// decomposer side
	modport src (output sgn, exp, man, zero, nan, qnan, snan);

	// comparator side
	modport dst (input sgn, exp, man, zero, nan, qnan, snan);

endinterface

/* src/fp_decomp.sv */
// split a binary32 word into fields and classify it
module fp_decomp (
	input  logic [fp_pkg::fp_wid-1:0] i,
	fp_parts_if.src                   parts
);

	// ====================================================================
	// field slicing
	// ====================================================================

	// biased exponent field
	logic [fp_pkg::fp_emsb:0] exp_f;
	// fraction field
	logic [fp_pkg::fp_fmsb:0] frac_f;
	// exponent is all ones
	logic                     exp_ones;
	// exponent is all zeros
	logic                     exp_zero;
	// fraction has at least one bit set
	logic                     frac_nz;

	assign exp_f  = i[fp_pkg::fp_wid-2:fp_pkg::fp_fmsb+1];
	assign frac_f = i[fp_pkg::fp_fmsb:0];

	assign exp_ones = &exp_f;
	assign exp_zero = ~|exp_f;
	assign frac_nz  = |frac_f;

	// sign is the top bit
	assign parts.sgn = i[fp_pkg::fp_wid-1];
	assign parts.exp = exp_f;
	assign parts.man = frac_f;

	// ====================================================================
	// classification
	// ====================================================================

	// both signed zeros land here
	assign parts.zero = exp_zero & ~frac_nz;

	// all-ones exponent with any fraction bit set
	// infinity has a zero fraction and is not a nan
	assign parts.nan = exp_ones & frac_nz;

	// the fraction msb is the quiet bit
	assign parts.qnan = exp_ones & frac_f[fp_pkg::fp_fmsb];

	// quiet bit clear but some lower bit set
	assign parts.snan = exp_ones & ~frac_f[fp_pkg::fp_fmsb] & (|frac_f[fp_pkg::fp_fmsb-1:0]);

	// the two nan kinds split the nan class exactly
	always_comb
	begin
		assert (!(parts.qnan && parts.snan))
			else $error("fp_decomp: qnan and snan both set");
		assert (parts.nan == (parts.qnan | parts.snan))
			else $error("fp_decomp: nan differs from qnan|snan");
	end

endmodule

/* src/fp_cmp_unit.sv */
// combinational compare of two decomposed binary32 operands
module fp_cmp_unit (
	// clk and arst_n only sample the assertions below
	// nothing in the compare path is clocked
	input  logic                    clk,
	input  logic                    arst_n,
	fp_parts_if.dst                 pa,
	fp_parts_if.dst                 pb,
	output logic [fp_pkg::cond_w-1:0] cond,
	output logic                    snan_any
);

	// ====================================================================
	// magnitude compare
	// ====================================================================

	// exponent over fraction orders magnitudes as plain integers
	// subnormals need no special case since their exponent is zero
	logic [fp_pkg::fp_wid-2:0] mag_a;
	logic [fp_pkg::fp_wid-2:0] mag_b;
	logic                      mlt;
	logic                      mgt;
	logic                      meq;

	assign mag_a = {pa.exp, pa.man};
	assign mag_b = {pb.exp, pb.man};

	assign mlt = mag_a < mag_b;
	assign mgt = mag_a > mag_b;
	assign meq = mag_a == mag_b;

	// ====================================================================
	// signed compare
	// ====================================================================

	logic both_zero;
	logic unord;
	logic eq_raw;
	logic lt_raw;
	logic le_raw;
	logic eq;
	logic lt;
	logic le;

	// +0 and -0 compare equal
	assign both_zero = pa.zero & pb.zero;

	// any nan makes the pair unordered
	assign unord = pa.nan | pb.nan;

	// identical bit patterns or two zeros
	assign eq_raw = both_zero | ((pa.sgn == pb.sgn) & meq);

	// signs differ
	//   a is less when a is negative, unless both are zero
	// both negative
	//   larger magnitude is the smaller number
	// both positive
	//   plain magnitude order
	assign lt_raw = (pa.sgn ^ pb.sgn) ? (pa.sgn & ~both_zero) :
		pa.sgn ? mgt : mlt;

	// a <= b straight from the magnitude compare
	// signs differ
	//   a is not above b when a is negative or both are zero
	// both negative
	//   magnitude of a is not below that of b
	// both positive
	//   magnitude of a is not above that of b
	assign le_raw = (pa.sgn ^ pb.sgn) ? (pa.sgn | both_zero) :
		pa.sgn ? ~mlt : ~mgt;

	// unordered pairs are neither equal nor less
	assign eq = eq_raw & ~unord;
	assign lt = lt_raw & ~unord;
	assign le = le_raw & ~unord;

	// ====================================================================
	// outputs
	// ====================================================================

	always_comb
	begin
		cond                   = '0;
		cond[fp_pkg::cond_eq]  = eq;
		cond[fp_pkg::cond_lt]  = lt;
		cond[fp_pkg::cond_le]  = le;
		// mlt stays raw magnitude-less
		cond[fp_pkg::cond_mlt] = mlt;
		cond[fp_pkg::cond_un]  = unord;
	end

	// either operand signaling
	assign snan_any = pa.snan | pb.snan;

	// ====================================================================
	// checks
	// ====================================================================

	// equal and less are exclusive
	a_eq_lt_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(cond[fp_pkg::cond_eq] && cond[fp_pkg::cond_lt]))
		else $error("fp_cmp_unit: eq and lt both set");

	// le is the union of lt and eq
	a_le_union: assert property (@(posedge clk) disable iff (!arst_n)
		cond[fp_pkg::cond_le] == (cond[fp_pkg::cond_lt] | cond[fp_pkg::cond_eq]))
		else $error("fp_cmp_unit: le differs from lt|eq");

endmodule

/* src/fp_cmp_stage.sv */
// predicate select and result register
// also holds the sticky invalid flag
module fp_cmp_stage (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      in_valid,
	input  fp_pkg::cmp_op_e           op,
	input  logic [fp_pkg::cond_w-1:0] cond,
	input  logic                      snan_any,
	input  logic                      clr_flags,
	output logic                      out_valid,
	output logic                      res,
	output logic [fp_pkg::cond_w-1:0] cond_out,
	output logic                      nanx,
	output logic                      invalid_flag
);

	// ====================================================================
	// predicate select
	// ====================================================================

	// named condition bits
	logic c_eq;
	logic c_lt;
	logic c_le;
	logic c_un;

	assign c_eq = cond[fp_pkg::cond_eq];
	assign c_lt = cond[fp_pkg::cond_lt];
	assign c_le = cond[fp_pkg::cond_le];
	assign c_un = cond[fp_pkg::cond_un];

	// selected predicate
	logic sel_res;
	// exception for this compare
	logic exc;

	always_comb
	begin
		sel_res = 1'b0;
		exc     = 1'b0;
		unique case (op)
			fp_pkg::cmp_eq:
			begin
				sel_res = c_eq;
				exc     = snan_any;
			end
			fp_pkg::cmp_ne:
			begin
				// nan operands are never equal
				sel_res = ~c_eq;
				exc     = snan_any;
			end
			fp_pkg::cmp_lt:
			begin
				sel_res = c_lt;
				exc     = c_un;
			end
			fp_pkg::cmp_le:
			begin
				sel_res = c_le;
				exc     = c_un;
			end
			fp_pkg::cmp_gt:
			begin
				// gt is the complement of le within ordered pairs
				sel_res = ~c_le & ~c_un;
				exc     = c_un;
			end
			fp_pkg::cmp_ge:
			begin
				sel_res = ~c_lt & ~c_un;
				exc     = c_un;
			end
			fp_pkg::cmp_or:
			begin
				sel_res = ~c_un;
				exc     = snan_any;
			end
			fp_pkg::cmp_un:
			begin
				sel_res = c_un;
				exc     = snan_any;
			end
		endcase
	end

	// ====================================================================
	// result registers
	// ====================================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_valid    <= 1'b0;
			res          <= 1'b0;
			cond_out     <= '0;
			nanx         <= 1'b0;
			invalid_flag <= 1'b0;
		end
		else
		begin
			// one cycle from strobe to result
			out_valid <= in_valid;
			// exception is a pulse aligned to out_valid
			nanx      <= in_valid & exc;
			// result and conditions hold between samples
			if (in_valid)
			begin
				res      <= sel_res;
				cond_out <= cond;
			end
			// sticky flag with set taking priority over clear
			if (nanx)
				invalid_flag <= 1'b1;
			else if (clr_flags)
				invalid_flag <= 1'b0;
		end
	end

	// ====================================================================
	// checks
	// ====================================================================

	// an exception only comes with a result
	a_nanx_valid: assert property (@(posedge clk) disable iff (!arst_n)
		nanx |-> out_valid)
		else $error("fp_cmp_stage: nanx without out_valid");

	// every exception lands in the sticky flag
	a_flag_set: assert property (@(posedge clk) disable iff (!arst_n)
		nanx |=> invalid_flag)
		else $error("fp_cmp_stage: invalid_flag missed a nanx");

endmodule

/* src/fp_cmp_top.sv */
// registered binary32 compare unit
module fp_cmp_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [fp_pkg::fp_wid-1:0] a,
	input  logic [fp_pkg::fp_wid-1:0] b,
	input  fp_pkg::cmp_op_e           op,
	input  logic                      in_valid,
	input  logic                      clr_flags,
	output logic                      out_valid,
	output logic                      res,
	output logic [fp_pkg::cond_w-1:0] cond_out,
	output logic                      nanx,
	output logic                      invalid_flag
);

	// ====================================================================
	// operand decomposition
	// ====================================================================

	fp_parts_if parts_a ();
	fp_parts_if parts_b ();

	fp_decomp u_decomp_a (
		.i     (a),
		.parts (parts_a.src)
	);

	fp_decomp u_decomp_b (
		.i     (b),
		.parts (parts_b.src)
	);

	// ====================================================================
	// compare and result stage
	// ====================================================================

	// combinational conditions for the current operands
	logic [fp_pkg::cond_w-1:0] cond;
	logic                      snan_any;

	fp_cmp_unit u_cmp_unit (
		.clk      (clk),
		.arst_n   (arst_n),
		.pa       (parts_a.dst),
		.pb       (parts_b.dst),
		.cond     (cond),
		.snan_any (snan_any)
	);

	fp_cmp_stage u_cmp_stage (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.op           (op),
		.cond         (cond),
		.snan_any     (snan_any),
		.clr_flags    (clr_flags),
		.out_valid    (out_valid),
		.res          (res),
		.cond_out     (cond_out),
		.nanx         (nanx),
		.invalid_flag (invalid_flag)
	);

endmodule

/* verif/fp_cmp_ref.svh */
`ifndef FP_CMP_REF_SVH
`define FP_CMP_REF_SVH

// expected registered outputs for one compare
typedef struct packed {
	logic                      res;
	logic [fp_pkg::cond_w-1:0] cond;
	logic                      nanx;
} cmp_expect_t;

// binary32 compare worked out from the IEEE 754 rules
function automatic cmp_expect_t fp_cmp_ref(input logic [31:0] a, input logic [31:0] b,
	input fp_pkg::cmp_op_e op);
	cmp_expect_t e;
	logic        a_nan;
	logic        b_nan;
	logic        sig_nan;
	logic        un;
	longint      key_a;
	longint      key_b;
	// nan is an all-ones exponent with a nonzero fraction
	a_nan   = (&a[30:23]) && (|a[22:0]);
	b_nan   = (&b[30:23]) && (|b[22:0]);
	// fraction bit 22 clear marks a signaling nan
	sig_nan = (a_nan && !a[22]) || (b_nan && !b[22]);
	un      = a_nan || b_nan;
	// signed integer key, so both zeros land on 0 and negatives reverse
	key_a = a[31] ? -longint'(a[30:0]) : longint'(a[30:0]);
	key_b = b[31] ? -longint'(b[30:0]) : longint'(b[30:0]);
	e = '0;
	e.cond[fp_pkg::cond_eq]  = !un && (key_a == key_b);
	e.cond[fp_pkg::cond_lt]  = !un && (key_a < key_b);
	e.cond[fp_pkg::cond_le]  = !un && (key_a <= key_b);
	e.cond[fp_pkg::cond_mlt] = a[30:0] < b[30:0];
	e.cond[fp_pkg::cond_un]  = un;
	case (op)
		fp_pkg::cmp_eq: e.res = !un && (key_a == key_b);
		fp_pkg::cmp_ne: e.res = un || (key_a != key_b);
		fp_pkg::cmp_lt: e.res = !un && (key_a < key_b);
		fp_pkg::cmp_le: e.res = !un && (key_a <= key_b);
		fp_pkg::cmp_gt: e.res = !un && (key_a > key_b);
		fp_pkg::cmp_ge: e.res = !un && (key_a >= key_b);
		fp_pkg::cmp_or: e.res = !un;
		fp_pkg::cmp_un: e.res = un;
	endcase
	// ordering predicates signal on any nan, the quiet ones only on an snan
	e.nanx = (op inside {fp_pkg::cmp_lt, fp_pkg::cmp_le, fp_pkg::cmp_gt, fp_pkg::cmp_ge}) ?
		un : sig_nan;
	return e;
endfunction

`endif

/* verif/fp_cmp_tb.sv */
module fp_cmp_tb;

	`include "fp_cmp_ref.svh"

	// ====================================================================
	// test sizes and timeout
	// ====================================================================

	localparam int n_ordered = 96;
	// zeros, negative pairs and nans, 14 per opcode
	localparam int n_edge    = 112;
	localparam int n_sticky  = 6;
	localparam int n_mix     = 240;
	localparam int timeout_cycles = 4 * (n_ordered + n_edge + n_sticky + n_mix) + 100;

	logic                      clk = 1'b0;
	logic                      arst_n;
	logic [31:0]               a;
	logic [31:0]               b;
	fp_pkg::cmp_op_e           op;
	logic                      in_valid;
	logic                      clr_flags;
	logic                      out_valid;
	logic                      res;
	logic [fp_pkg::cond_w-1:0] cond_out;
	logic                      nanx;
	logic                      invalid_flag;

	int                        seed;
	int                        cycles;
	// expectations in issue order
	cmp_expect_t               exp_q[$];
	// checker model of the registered outputs
	cmp_expect_t               cur;
	logic                      prev_iv;
	logic                      exp_flag;
	logic                      last_res;
	logic [fp_pkg::cond_w-1:0] last_cond;

	fp_cmp_top uut (.*);

	always #10 clk = ~clk;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(input string field, input logic [31:0] got,
		input logic [31:0] want);
		stop_with_error($sformatf("Mismatch at time %0t: %s is %0h, expected %0h",
			$time, field, got, want));
	endtask

	// one strobe, sampled at the next rising edge
	task automatic issue_compare(input logic [31:0] x, input logic [31:0] y,
		input fp_pkg::cmp_op_e p);
		a        = x;
		b        = y;
		op       = p;
		in_valid = 1'b1;
		exp_q.push_back(fp_cmp_ref(x, y, p));
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// random binary32 word, normal only or from any class
	function automatic logic [31:0] rand_word(input logic any_class);
		logic [31:0] r;
		logic [31:0] f;
		r = $random(seed);
		f = $random(seed);
		// normal exponent stays in 1..254
		if (!any_class || r[2:0] > 3'd4)
			return {r[31], 8'd1 + r[15:8] % 8'd254, f[22:0]};
		case (r[2:0])
			3'd0: return {r[31], 31'd0};
			3'd1: return {r[31], 8'd0, f[22:1], 1'b1};
			3'd2: return {r[31], 8'hff, 23'd0};
			3'd3: return {r[31], 8'hff, 1'b1, f[21:0]};
			default: return {r[31], 8'hff, 1'b0, f[21:1], 1'b1};
		endcase
	endfunction

	// ====================================================================
	// checker, at the falling edge where outputs are settled
	// ====================================================================

	always @(negedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > timeout_cycles)
			stop_with_error("timeout: the test did not finish within its cycle limit");
		if (!arst_n)
		begin
			prev_iv   = 1'b0;
			exp_flag  = 1'b0;
			last_res  = 1'b0;
			last_cond = '0;
		end
		cur = '0;
		// result exactly one cycle after the strobe
		assert (out_valid == prev_iv)
			else report_mismatch("out_valid", 32'(out_valid), 32'(prev_iv));
		if (out_valid)
		begin
			assert (exp_q.size() != 0)
				else stop_with_error("out_valid came with no compare outstanding");
			cur       = exp_q.pop_front();
			last_res  = cur.res;
			last_cond = cur.cond;
		end
		// res and cond_out hold between results
		assert (res == last_res)
			else report_mismatch("res", 32'(res), 32'(last_res));
		assert (cond_out == last_cond)
			else report_mismatch("cond_out", 32'(cond_out), 32'(last_cond));
		assert (nanx == cur.nanx)
			else report_mismatch("nanx", 32'(nanx), 32'(cur.nanx));
		assert (invalid_flag == exp_flag)
			else report_mismatch("invalid_flag", 32'(invalid_flag), 32'(exp_flag));
		// next edge, set beats clear
		if (arst_n && cur.nanx)
			exp_flag = 1'b1;
		else if (arst_n && clr_flags)
			exp_flag = 1'b0;
		prev_iv = arst_n & in_valid;
	end

	initial
	begin
		logic [31:0]     x;
		logic [31:0]     y;
		logic [31:0]     c;
		fp_pkg::cmp_op_e p;
		seed      = 32'h8077_d57f;
		arst_n    = 1'b0;
		a         = '0;
		b         = '0;
		op        = fp_pkg::cmp_eq;
		in_valid  = 1'b0;
		clr_flags = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// ordered normals, every opcode in turn, back to back
		for (int i = 0; i < n_ordered; i++)
		begin
			x = rand_word(1'b0);
			c = $random(seed);
			// equal, sign flipped, or an independent normal
			y = c[1] ? {c[0] ^ x[31], x[30:0]} : rand_word(1'b0);
			issue_compare(x, y, fp_pkg::cmp_op_e'(3'(i)));
		end
		for (int k = 0; k < 8; k++)
		begin
			p = fp_pkg::cmp_op_e'(3'(k));
			// all four signed zero pairs, then negative pairs
			for (int j = 0; j < 4; j++)
			begin
				issue_compare({j[0], 31'd0}, {j[1], 31'd0}, p);
				x = rand_word(1'b0);
				y = rand_word(1'b0);
				issue_compare({1'b1, x[30:0]}, {1'b1, y[30:0]}, p);
			end
			// quiet nans
			issue_compare(32'h7fc0_0000, x, p);
			issue_compare(x, 32'hffc0_0001, p);
			issue_compare(32'h7fc0_0000, 32'h7fc1_2345, p);
			// signaling nans
			issue_compare(32'h7f80_0001, x, p);
			issue_compare(x, 32'hff80_4000, p);
			issue_compare(32'h7f80_0001, 32'h7fc0_0000, p);
		end
		// sticky flag, cleared first since earlier nans set it
		// the last nan exception lands before the clear
		wait_cycles(1);
		clr_flags = 1'b1;
		wait_cycles(1);
		clr_flags = 1'b0;
		issue_compare(32'h3f80_0000, 32'h4000_0000, fp_pkg::cmp_lt);
		wait_cycles(2);
		issue_compare(32'h7fc0_0000, 32'h3f80_0000, fp_pkg::cmp_lt);
		// clean compares leave it set
		for (int i = 0; i < 3; i++)
			issue_compare(32'h3f80_0000, 32'h3f80_0000, fp_pkg::cmp_ge);
		clr_flags = 1'b1;
		wait_cycles(1);
		clr_flags = 1'b0;
		wait_cycles(2);
		// the clear lands on the same edge as this nanx
		issue_compare(32'h7f80_0001, 32'h0000_0000, fp_pkg::cmp_eq);
		clr_flags = 1'b1;
		wait_cycles(1);
		clr_flags = 1'b0;
		wait_cycles(3);
		// any class, with equal pairs, mostly back to back
		for (int i = 0; i < n_mix; i++)
		begin
			x = rand_word(1'b1);
			c = $random(seed);
			y = (c[1:0] == 2'd0) ? x : rand_word(1'b1);
			issue_compare(x, y, fp_pkg::cmp_op_e'(c[4:2]));
			if (c[6:5] == 2'd3)
				wait_cycles(int'(c[8:7]) + 1);
		end
		wait_cycles(4);
		if (exp_q.size() == 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
			stop_with_error($sformatf("%0d results never arrived", exp_q.size()));
	end

endmodule

/* verilog.f */
+incdir+verif
src/fp_pkg.sv
src/fp_parts_if.sv
src/fp_decomp.sv
src/fp_cmp_unit.sv
src/fp_cmp_stage.sv
src/fp_cmp_top.sv
verif/fp_cmp_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fp_cmp_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
